//--- Makefile
VERILATOR  = verilator
TOP        = tb_memMux
FILELIST   = sources.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_TEXT  = >>> FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF -- '$(FAIL_TEXT)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/memTargetModel.sv
`default_nettype none
`timescale 1ns/1ps

`include "memMux_params.svh"

module memTargetModel import memMuxPkg::*; #(
	parameter int INDEX = 0
) (
	input wire CLK,
	input wire RESETn,
	input wire act,
	input wire memWrite,
	input wire [`MM_ADDR_W-1:0] memAddr,
	input wire memTagT memTag,
	output logic next,
	output logic rdDrdy,
	output logic [`MM_DATA_W-1:0] rdData,
	output memTagT rdTag
);

	int cycle;
	int due;
	int lastDue;
	int writeCount;
	int dueQ [$];
	logic [`MM_ADDR_W-1:0] addrQ [$];
	memTagT tagQ [$];

	// read data is a fixed function of address and target index
	function automatic logic [`MM_DATA_W-1:0] pattern(input logic [`MM_ADDR_W-1:0] a);
		return {a[27:0], 4'(INDEX), a[31:0]} ^ 64'h0123_4567_89AB_CDEF;
	endfunction

	initial begin
		cycle = 0;
		lastDue = 0;
		writeCount = 0;
		next = 1'b1;
		rdDrdy = 1'b0;
		rdData = '0;
		rdTag = '0;
	end

	always begin
		@(negedge CLK);
		// handshake that completes on the coming edge
		if (RESETn && act && next) begin
			if (memWrite) begin
				writeCount++;
			end else begin
				due = cycle + 2 + int'($urandom_range(5, 0));
				if (due <= lastDue)
					due = lastDue + 1;
				lastDue = due;
				dueQ.push_back(due);
				addrQ.push_back(memAddr);
				tagQ.push_back(memTag);
			end
		end
		@(posedge CLK);
		cycle++;
		#1;
		// stall about one cycle in four
		next = ($urandom_range(3, 0) != 0);
		rdDrdy = 1'b0;
		if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
			void'(dueQ.pop_front());
			rdData = pattern(addrQ.pop_front());
			rdTag = tagQ.pop_front();
			rdDrdy = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_memMux.sv
`default_nettype none
`timescale 1ns/1ps

`include "memMux_params.svh"

module tb_memMux import memMuxPkg::*; ();

	localparam int TAGS = 1 << `MM_SRCTAG_W;

	logic CLK;
	logic RESETn;
	logic [`MM_CHANNELS-1:0] reqValid;
	logic [`MM_CHANNELS-1:0] reqWrite;
	logic [1:0] reqSize [`MM_CHANNELS];
	logic [`MM_ADDR_W-1:0] reqAddr [`MM_CHANNELS];
	logic [`MM_DATA_W-1:0] reqData [`MM_CHANNELS];
	logic [`MM_SRCTAG_W-1:0] reqTag [`MM_CHANNELS];
	wire [`MM_CHANNELS-1:0] reqReady;
	wire memWrite;
	wire [`MM_ADDR_W-1:0] memAddr;
	wire [`MM_DATA_W-1:0] memData;
	wire [`MM_DATA_W/8-1:0] memByteEnN;
	wire memTagT memTag;
	wire [`MM_TARGETS-1:0] act;
	wire [`MM_TARGETS-1:0] next;
	wire [`MM_TARGETS-1:0] rdDrdy;
	wire [`MM_DATA_W-1:0] rdData [`MM_TARGETS];
	wire memTagT rdTag [`MM_TARGETS];
	wire [`MM_CHANNELS-1:0] respValid;
	wire [`MM_DATA_W-1:0] respData;
	wire [`MM_SRCTAG_W-1:0] respTag;
	wire [1:0] respSize;
	wire [`MM_SRCTAG_W-1:0] busTag;

	// expected values, indexed by caller tag
	logic [`MM_ADDR_W-1:0] expAddr [TAGS];
	logic [`MM_DATA_W-1:0] expData [TAGS];
	logic [7:0] expEnN [TAGS];
	logic [2:0] expChan [TAGS];
	logic [1:0] expSize [TAGS];
	logic expWrite [TAGS];
	int retCount [TAGS];
	int errors;
	int reads;
	int writes;
	int returned;
	int nextTag;
	int ticks;
	int written;

	assign busTag = memTag.srcTag;

	memMux dut (.*);

	for (genvar t = 0; t < `MM_TARGETS; t++) begin : gModel
		memTargetModel #(.INDEX(t)) model (
			.CLK(CLK), .RESETn(RESETn), .act(act[t]), .memWrite(memWrite),
			.memAddr(memAddr), .memTag(memTag), .next(next[t]),
			.rdDrdy(rdDrdy[t]), .rdData(rdData[t]), .rdTag(rdTag[t])
		);
	end

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// ----------------------------------------------------------------------
	// reference rules
	// ----------------------------------------------------------------------
	function automatic logic [2:0] targetOf(input logic [`MM_ADDR_W-1:0] a);
		if (a < `MM_FLASH_END)
			return 3'b001;
		if (a < `MM_IO_BASE)
			return 3'b010;
		return 3'b100;
	endfunction

	// same read pattern as the responders
	function automatic logic [63:0] pattern(input logic [`MM_ADDR_W-1:0] a, input int t);
		return {a[27:0], t[3:0], a[31:0]} ^ 64'h0123_4567_89AB_CDEF;
	endfunction

	function automatic logic [7:0] enableN(input int off, input int size);
		int first;
		logic [7:0] en;
		first = (off >> size) << size;
		for (int i = 0; i < 8; i++)
			en[i] = !(i >= first && i < first + (1 << size));
		return en;
	endfunction

	function automatic logic [63:0] spread(input logic [63:0] d, input int size);
		logic [63:0] r;
		for (int i = 0; i < 8; i++)
			r[i*8 +: 8] = d[(i % (1 << size))*8 +: 8];
		return r;
	endfunction

	function automatic logic [63:0] extract(input logic [63:0] p, input int off, input int size);
		logic [63:0] r;
		r = p >> (((off >> size) << size) * 8);
		if (size < 3)
			r &= (64'd1 << (8 << size)) - 64'd1;
		return r;
	endfunction

	// neighbour wins, otherwise the lowest set bit
	function automatic logic [5:0] winner(input logic [5:0] v);
		if (v[`MM_HCHAN])
			return 6'b1 << `MM_HCHAN;
		return v & (~v + 6'd1);
	endfunction

	task automatic reportMismatch(input string name, input logic [63:0] expVal,
			input logic [63:0] gotVal);
		errors++;
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
	endtask

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	actDecode: assert property (@(posedge CLK) disable iff (!RESETn)
		|act |-> act == targetOf(expAddr[busTag]))
		else reportMismatch("act", targetOf(expAddr[$sampled(busTag)]), $sampled(act));
	busAddr: assert property (@(posedge CLK) disable iff (!RESETn)
		|act |-> memAddr == expAddr[busTag])
		else reportMismatch("memAddr", expAddr[$sampled(busTag)], $sampled(memAddr));
	busCommand: assert property (@(posedge CLK) disable iff (!RESETn)
		|act |-> memWrite == expWrite[busTag])
		else reportMismatch("memWrite", expWrite[$sampled(busTag)], $sampled(memWrite));
	busChan: assert property (@(posedge CLK) disable iff (!RESETn)
		|act |-> memTag.chan == expChan[busTag])
		else reportMismatch("memTag.chan", expChan[$sampled(busTag)], $sampled(memTag.chan));
	busEnables: assert property (@(posedge CLK) disable iff (!RESETn)
		|act |-> memByteEnN == expEnN[busTag])
		else reportMismatch("memByteEnN", expEnN[$sampled(busTag)], $sampled(memByteEnN));
	busWriteData: assert property (@(posedge CLK) disable iff (!RESETn)
		|act && memWrite |-> memData == expData[busTag])
		else reportMismatch("memData", expData[$sampled(busTag)], $sampled(memData));
	readyPriority: assert property (@(posedge CLK) disable iff (!RESETn)
		|reqReady |-> reqReady == winner(reqValid))
		else reportMismatch("reqReady", winner($sampled(reqValid)), $sampled(reqReady));
	stallNoReady: assert property (@(posedge CLK) disable iff (!RESETn)
		|(act & ~next) |-> reqReady == '0)
		else reportMismatch("reqReady", '0, $sampled(reqReady));
	stallHolds: assert property (@(posedge CLK) disable iff (!RESETn)
		|(act & ~next) |=> $stable(act) && $stable(memAddr) && $stable(memTag)
			&& $stable(memByteEnN))
		else begin
			errors++;
			$display("bus request changed at %0t while its target held next low", $time);
		end
	respChannel: assert property (@(posedge CLK) disable iff (!RESETn)
		|respValid |-> respValid == (6'b1 << expChan[respTag]))
		else reportMismatch("respValid", 6'b1 << expChan[$sampled(respTag)], $sampled(respValid));
	respDataOk: assert property (@(posedge CLK) disable iff (!RESETn)
		|respValid |-> respData == expData[respTag])
		else reportMismatch("respData", expData[$sampled(respTag)], $sampled(respData));
	respSizeOk: assert property (@(posedge CLK) disable iff (!RESETn)
		|respValid |-> respSize == expSize[respTag])
		else reportMismatch("respSize", expSize[$sampled(respTag)], $sampled(respSize));
	respOnce: assert property (@(posedge CLK) disable iff (!RESETn)
		|respValid |-> retCount[respTag] == 0)
		else begin
			errors++;
			$display("tag %0d returned more than once at %0t", $sampled(respTag), $time);
		end

	always @(posedge CLK) begin
		if (RESETn && |respValid) begin
			retCount[respTag] <= retCount[respTag] + 1;
			returned <= returned + 1;
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	task automatic issue(input int ch, input logic wr, input int size,
			input logic [`MM_ADDR_W-1:0] a, input logic [`MM_DATA_W-1:0] d);
		int tag;
		int waited;
		tag = nextTag;
		nextTag++;
		expAddr[tag] = a;
		expChan[tag] = ch[2:0];
		expSize[tag] = size[1:0];
		expWrite[tag] = wr;
		expEnN[tag] = enableN(int'(a[2:0]), size);
		if (wr) begin
			expData[tag] = spread(d, size);
			writes++;
		end else begin
			expData[tag] = extract(pattern(a, $clog2(targetOf(a))), int'(a[2:0]), size);
			reads++;
		end
		reqWrite[ch] = wr;
		reqSize[ch] = size[1:0];
		reqAddr[ch] = a;
		reqData[ch] = d;
		reqTag[ch] = tag[`MM_SRCTAG_W-1:0];
		reqValid[ch] = 1'b1;
		waited = 0;
		do begin
			@(negedge CLK);
			waited++;
		end while (!reqReady[ch] && waited < 200);
		if (!reqReady[ch]) begin
			errors++;
			$display("channel %0d request with tag %0d was never accepted", ch, tag);
		end
		@(posedge CLK);
		#1 reqValid[ch] = 1'b0;
	endtask

	// channels in the mask all raise valid in the same cycle
	task automatic burst(input logic [5:0] m, input int r);
		fork
			if (m[0]) issue(0, 0, r % 4, 45'h7000 + r * 64, '0);
			if (m[1]) issue(1, 0, 3, `MM_FLASH_END + r * 64, '0);
			if (m[2]) issue(2, 1, 2, `MM_IO_BASE + r * 64, 64'h1111_2222_3333_4444);
			if (m[3]) issue(3, 0, 1, 45'h7802 + r * 64, '0);
			if (m[4]) issue(4, 0, 0, `MM_FLASH_END + 45'h805 + r * 64, '0);
			if (m[5]) issue(5, 0, 3, `MM_IO_BASE + 45'h808 + r * 64, '0);
		join
	endtask

	initial begin
		void'($urandom(10));
		RESETn = 1'b0;
		reqValid = '0;
		reqWrite = '0;
		for (int c = 0; c < `MM_CHANNELS; c++) begin
			reqSize[c] = '0;
			reqAddr[c] = '0;
			reqData[c] = '0;
			reqTag[c] = '0;
		end
		repeat (2) @(posedge CLK);
		#1 RESETn = 1'b1;

		// routing, one read per channel
		for (int c = 0; c < `MM_CHANNELS; c++)
			issue(c, 0, 3, `MM_IO_BASE + c * 8, '0);
		// lane extraction and write formatting over every size and offset
		for (int s = 0; s < 4; s++) begin
			for (int o = 0; o < 8; o++) begin
				issue((s * 8 + o) % 6, 0, s, `MM_FLASH_END + 45'h2000 + o, '0);
				issue(2, 1, s, 45'h3000 + o, {$urandom, $urandom});
			end
		end
		// map edges
		issue(1, 0, 3, `MM_FLASH_END - 8, '0);
		issue(1, 0, 3, `MM_FLASH_END, '0);
		issue(4, 0, 3, `MM_IO_BASE - 8, '0);
		issue(4, 0, 3, `MM_IO_BASE, '0);
		// competing channels under random stalls
		for (int r = 0; r < 16; r++)
			burst(6'($urandom_range(63, 1)), r);

		ticks = 0;
		while (returned != reads && ticks < 1000) begin
			@(negedge CLK);
			ticks++;
		end
		if (returned != reads) begin
			errors++;
			$display("%0d responses seen for %0d reads before the timeout", returned, reads);
		end
		written = gModel[0].model.writeCount + gModel[1].model.writeCount
			+ gModel[2].model.writeCount;
		if (written != writes) begin
			errors++;
			$display("responders took %0d writes, %0d were issued", written, writes);
		end
		$display("errors %0d, reads %0d, responses %0d, writes %0d", errors, reads, returned,
			writes);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- include/memMux_params.svh
`ifndef MEMMUX_PARAMS_SVH
`define MEMMUX_PARAMS_SVH

// ----------------------------------------------------------------------
// channel side
// ----------------------------------------------------------------------
`define MM_CHANNELS 6
// neighbour core, highest priority
`define MM_HCHAN 5
`define MM_CHAN_W 3
// caller tag carried through unchanged
`define MM_SRCTAG_W 13

// ----------------------------------------------------------------------
// memory bus and targets
// ----------------------------------------------------------------------
`define MM_ADDR_W 45
`define MM_DATA_W 64
`define MM_TARGETS 3
`define MM_TGT_FLASH 0
`define MM_TGT_SDRAM 1
`define MM_TGT_IO 2

// response FIFO per target, count saturates at full
`define MM_FIFO_DEPTH 16
`define MM_FIFO_CNT_W 4

// address map, I/O runs to the top of the space
`define MM_FLASH_END 45'h0000_4000_0000
`define MM_IO_BASE 45'h1FFF_FFFF_0000

`endif

//--- rtl/memMux.sv
`default_nettype none
`timescale 1ns/1ps

`include "memMux_params.svh"

module memMux import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,
	// channel requests
	input wire [`MM_CHANNELS-1:0] reqValid,
	input wire [`MM_CHANNELS-1:0] reqWrite,
	input wire [1:0] reqSize [`MM_CHANNELS],
	input wire [`MM_ADDR_W-1:0] reqAddr [`MM_CHANNELS],
	input wire [`MM_DATA_W-1:0] reqData [`MM_CHANNELS],
	input wire [`MM_SRCTAG_W-1:0] reqTag [`MM_CHANNELS],
	output wire [`MM_CHANNELS-1:0] reqReady,
	// shared memory bus
	output wire memWrite,
	output wire [`MM_ADDR_W-1:0] memAddr,
	output wire [`MM_DATA_W-1:0] memData,
	output wire [`MM_DATA_W/8-1:0] memByteEnN,
	output wire memTagT memTag,
	// per target handshake and responses
	output wire [`MM_TARGETS-1:0] act,
	input wire [`MM_TARGETS-1:0] next,
	input wire [`MM_TARGETS-1:0] rdDrdy,
	input wire [`MM_DATA_W-1:0] rdData [`MM_TARGETS],
	input wire memTagT rdTag [`MM_TARGETS],
	// channel responses
	output wire [`MM_CHANNELS-1:0] respValid,
	output wire [`MM_DATA_W-1:0] respData,
	output wire [`MM_SRCTAG_W-1:0] respTag,
	output wire [1:0] respSize
);

	wire busValid;
	wire [`MM_TARGETS-1:0] busTarget;
	wire [`MM_TARGETS-1:0] busTaken;
	wire [`MM_DATA_W-1:0] fifoData [`MM_TARGETS];
	wire memTagT fifoTag [`MM_TARGETS];
	wire [`MM_TARGETS-1:0] fifoEmpty;
	wire [`MM_FIFO_CNT_W-1:0] fifoCount [`MM_TARGETS];
	wire [`MM_TARGETS-1:0] fifoPop;

	requestArbiter arbiter (
		.CLK(CLK),
		.RESETn(RESETn),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqSize(reqSize),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqTag(reqTag),
		.busTaken(busTaken),
		.reqReady(reqReady),
		.busValid(busValid),
		.busTarget(busTarget),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memData(memData),
		.memByteEnN(memByteEnN),
		.memTag(memTag)
	);

	// flash, SDRAM and I/O in target index order
	for (genvar t = 0; t < `MM_TARGETS; t++) begin : gTarget
		targetPort port (
			.CLK(CLK),
			.RESETn(RESETn),
			.busValid(busValid),
			.busSelect(busTarget[t]),
			.next(next[t]),
			.rdDrdy(rdDrdy[t]),
			.rdData(rdData[t]),
			.rdTag(rdTag[t]),
			.fifoPop(fifoPop[t]),
			.act(act[t]),
			.busTaken(busTaken[t]),
			.fifoData(fifoData[t]),
			.fifoTag(fifoTag[t]),
			.fifoEmpty(fifoEmpty[t]),
			.fifoCount(fifoCount[t])
		);
	end

	responseMerge merge (
		.CLK(CLK),
		.RESETn(RESETn),
		.fifoData(fifoData),
		.fifoTag(fifoTag),
		.fifoEmpty(fifoEmpty),
		.fifoCount(fifoCount),
		.fifoPop(fifoPop),
		.respValid(respValid),
		.respData(respData),
		.respTag(respTag),
		.respSize(respSize)
	);

endmodule

`default_nettype wire

//--- rtl/memMuxPkg.sv
`default_nettype none

`include "memMux_params.svh"

package memMuxPkg;

	// ------------------------------------------------------------------
	// lane code, low address bits and transfer size
	// ------------------------------------------------------------------

	// size field: 0 byte, 1 half, 2 word, 3 double
	typedef struct packed {
		logic [2:0] offset;
		logic [1:0] size;
	} laneFieldsT;

	// same 5 bits seen as one case selector or as its two fields
	typedef union packed {
		logic [4:0] code;
		laneFieldsT fields;
	} laneCodeT;

	// ------------------------------------------------------------------
	// tag sent with every bus request and echoed by the target
	// ------------------------------------------------------------------
	typedef struct packed {
		laneCodeT lane;
		logic [`MM_CHAN_W-1:0] chan;
		logic [`MM_SRCTAG_W-1:0] srcTag;
	} memTagT;

endpackage

`default_nettype wire

//--- rtl/requestArbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "memMux_params.svh"

module requestArbiter import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire [`MM_CHANNELS-1:0] reqValid,
	input wire [`MM_CHANNELS-1:0] reqWrite,
	input wire [1:0] reqSize [`MM_CHANNELS],
	input wire [`MM_ADDR_W-1:0] reqAddr [`MM_CHANNELS],
	input wire [`MM_DATA_W-1:0] reqData [`MM_CHANNELS],
	input wire [`MM_SRCTAG_W-1:0] reqTag [`MM_CHANNELS],
	input wire [`MM_TARGETS-1:0] busTaken,
	output logic [`MM_CHANNELS-1:0] reqReady,
	output logic busValid,
	output logic [`MM_TARGETS-1:0] busTarget,
	output logic memWrite,
	output logic [`MM_ADDR_W-1:0] memAddr,
	output logic [`MM_DATA_W-1:0] memData,
	output logic [`MM_DATA_W/8-1:0] memByteEnN,
	output memTagT memTag
);

	logic [`MM_CHAN_W-1:0] winIdx;
	logic [`MM_ADDR_W-1:0] winAddr;
	laneCodeT winLane;
	logic stageFree;
	logic accept;

	// active low enables, unit aligned down to its own size
	function automatic logic [`MM_DATA_W/8-1:0] laneEnN(laneCodeT lc);
		logic [`MM_DATA_W/8-1:0] unit;
		logic [2:0] base;
		case (lc.fields.size)
			2'd0: unit = 8'b0000_0001;
			2'd1: unit = 8'b0000_0011;
			2'd2: unit = 8'b0000_1111;
			default: unit = 8'b1111_1111;
		endcase
		base = lc.fields.offset & ~((3'd1 << lc.fields.size) - 3'd1);
		return ~(unit << base);
	endfunction

	// copy the low unit into every lane
	function automatic logic [`MM_DATA_W-1:0] replicate(logic [`MM_DATA_W-1:0] d,
			logic [1:0] size);
		case (size)
			2'd0: return {8{d[7:0]}};
			2'd1: return {4{d[15:0]}};
			2'd2: return {2{d[31:0]}};
			default: return d;
		endcase
	endfunction

	function automatic logic [`MM_TARGETS-1:0] decodeTarget(logic [`MM_ADDR_W-1:0] a);
		logic [`MM_TARGETS-1:0] hot;
		hot = '0;
		if (a < `MM_FLASH_END)
			hot[`MM_TGT_FLASH] = 1'b1;
		else if (a < `MM_IO_BASE)
			hot[`MM_TGT_SDRAM] = 1'b1;
		else
			hot[`MM_TGT_IO] = 1'b1;
		return hot;
	endfunction

	// ------------------------------------------------------------------
	// fixed priority, neighbour first then lowest channel number
	// ------------------------------------------------------------------
	always_comb begin
		winIdx = '0;
		for (int c = `MM_CHANNELS - 1; c >= 0; c--) begin
			if (reqValid[c] && c != `MM_HCHAN)
				winIdx = c[`MM_CHAN_W-1:0];
		end
		if (reqValid[`MM_HCHAN])
			winIdx = `MM_HCHAN;

		winAddr = reqAddr[winIdx];
		winLane.fields.offset = winAddr[2:0];
		winLane.fields.size = reqSize[winIdx];

		// stage can take a new request while its current one leaves
		stageFree = !busValid || (|busTaken);
		accept = (|reqValid) && stageFree;

		reqReady = '0;
		if (accept)
			reqReady[winIdx] = 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			busValid <= 1'b0;
			busTarget <= '0;
		end else if (accept) begin
			busValid <= 1'b1;
			busTarget <= decodeTarget(winAddr);
		end else if (stageFree) begin
			busValid <= 1'b0;
			busTarget <= '0;
		end
	end

	// shared bus payload
	always_ff @(posedge CLK) begin
		if (accept) begin
			memWrite <= reqWrite[winIdx];
			memAddr <= winAddr;
			memData <= replicate(reqData[winIdx], reqSize[winIdx]);
			memByteEnN <= laneEnN(winLane);
			memTag.lane <= winLane;
			memTag.chan <= winIdx;
			memTag.srcTag <= reqTag[winIdx];
		end
	end

	busTargetOneHot: assert property (@(posedge CLK) disable iff (!RESETn)
		busValid |-> $onehot(busTarget))
		else $error("busTarget %b not one-hot while busValid", busTarget);

endmodule

`default_nettype wire

//--- rtl/responseMerge.sv
`default_nettype none
`timescale 1ns/1ps

`include "memMux_params.svh"

module responseMerge import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire [`MM_DATA_W-1:0] fifoData [`MM_TARGETS],
	input wire memTagT fifoTag [`MM_TARGETS],
	input wire [`MM_TARGETS-1:0] fifoEmpty,
	input wire [`MM_FIFO_CNT_W-1:0] fifoCount [`MM_TARGETS],
	output logic [`MM_TARGETS-1:0] fifoPop,
	output logic [`MM_CHANNELS-1:0] respValid,
	output logic [`MM_DATA_W-1:0] respData,
	output logic [`MM_SRCTAG_W-1:0] respTag,
	output logic [1:0] respSize
);

	int selIdx;
	logic found;
	logic [`MM_FIFO_CNT_W-1:0] bestCount;
	logic holdValid;
	logic [`MM_DATA_W-1:0] holdData;
	memTagT holdTag;
	logic [`MM_DATA_W-1:0] extData;
	logic [`MM_CHANNELS-1:0] chanHot;

	// ------------------------------------------------------------------
	// pick the fullest FIFO, lower target index on a tie
	// ------------------------------------------------------------------
	always_comb begin
		found = 1'b0;
		bestCount = '0;
		selIdx = 0;
		for (int t = 0; t < `MM_TARGETS; t++) begin
			if (!fifoEmpty[t] && (!found || fifoCount[t] > bestCount)) begin
				found = 1'b1;
				bestCount = fifoCount[t];
				selIdx = t;
			end
		end
		fifoPop = '0;
		if (found)
			fifoPop[selIdx] = 1'b1;
	end

	// holding register
	always_ff @(posedge CLK) begin
		if (!RESETn)
			holdValid <= 1'b0;
		else
			holdValid <= found;
	end

	always_ff @(posedge CLK) begin
		if (found) begin
			holdData <= fifoData[selIdx];
			holdTag <= fifoTag[selIdx];
		end
	end

	// ------------------------------------------------------------------
	// lane extraction and channel decode
	// ------------------------------------------------------------------
	always_comb begin
		extData = '0;
		casez (holdTag.lane.code)
			5'b???00: extData[7:0] = holdData[{holdTag.lane.fields.offset, 3'b000} +: 8];
			5'b00?01: extData[15:0] = holdData[15:0];
			5'b01?01: extData[15:0] = holdData[31:16];
			5'b10?01: extData[15:0] = holdData[47:32];
			5'b11?01: extData[15:0] = holdData[63:48];
			5'b0??10: extData[31:0] = holdData[31:0];
			5'b1??10: extData[31:0] = holdData[63:32];
			default: extData = holdData;
		endcase

		for (int c = 0; c < `MM_CHANNELS; c++)
			chanHot[c] = holdValid && (int'(holdTag.chan) == c);
	end

	always_ff @(posedge CLK) begin
		if (!RESETn)
			respValid <= '0;
		else
			respValid <= chanHot;
	end

	always_ff @(posedge CLK) begin
		if (holdValid) begin
			respData <= extData;
			respTag <= holdTag.srcTag;
			respSize <= holdTag.lane.fields.size;
		end
	end

	popAtMostOne: assert property (@(posedge CLK) disable iff (!RESETn)
		$onehot0(fifoPop))
		else $error("more than one FIFO popped, fifoPop %b", fifoPop);

	respOneChannel: assert property (@(posedge CLK) disable iff (!RESETn)
		$onehot0(respValid))
		else $error("respValid %b not one-hot", respValid);

endmodule

`default_nettype wire

//--- rtl/targetPort.sv
`default_nettype none
`timescale 1ns/1ps

`include "memMux_params.svh"

module targetPort import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire busValid,
	input wire busSelect,
	input wire next,
	input wire rdDrdy,
	input wire [`MM_DATA_W-1:0] rdData,
	input wire memTagT rdTag,
	input wire fifoPop,
	output logic act,
	output logic busTaken,
	output logic [`MM_DATA_W-1:0] fifoData,
	output memTagT fifoTag,
	output logic fifoEmpty,
	output logic [`MM_FIFO_CNT_W-1:0] fifoCount
);

	logic [`MM_DATA_W-1:0] dataMem [`MM_FIFO_DEPTH];
	memTagT tagMem [`MM_FIFO_DEPTH];
	// one extra bit tells full from empty
	logic [`MM_FIFO_CNT_W:0] wrPtr;
	logic [`MM_FIFO_CNT_W:0] rdPtr;
	logic [`MM_FIFO_CNT_W:0] fill;
	logic fifoFull;

	// ------------------------------------------------------------------
	// activation handshake
	// ------------------------------------------------------------------

	// act follows the registered bus stage, so it drops on the
	// edge that sees next unless a new request for us replaces it
	always_comb begin
		act = busValid & busSelect;
		busTaken = act & next;
	end

	// ------------------------------------------------------------------
	// response FIFO
	// ------------------------------------------------------------------
	always_comb begin
		fill = wrPtr - rdPtr;
		fifoEmpty = (fill == '0);
		fifoFull = fill[`MM_FIFO_CNT_W];
		// 16 entries still read as 15
		fifoCount = fifoFull ? '1 : fill[`MM_FIFO_CNT_W-1:0];
		fifoData = dataMem[rdPtr[`MM_FIFO_CNT_W-1:0]];
		fifoTag = tagMem[rdPtr[`MM_FIFO_CNT_W-1:0]];
	end

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (rdDrdy)
				wrPtr <= wrPtr + 1'b1;
			if (fifoPop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rdDrdy) begin
			dataMem[wrPtr[`MM_FIFO_CNT_W-1:0]] <= rdData;
			tagMem[wrPtr[`MM_FIFO_CNT_W-1:0]] <= rdTag;
		end
	end

	// target has no back-pressure, merge must keep up
	fifoNoOverflow: assert property (@(posedge CLK) disable iff (!RESETn)
		rdDrdy |-> !fifoFull)
		else $error("response written into a full FIFO");

	fifoNoUnderflow: assert property (@(posedge CLK) disable iff (!RESETn)
		fifoPop |-> !fifoEmpty)
		else $error("pop from an empty response FIFO");

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
rtl/memMuxPkg.sv
rtl/requestArbiter.sv
rtl/targetPort.sv
rtl/responseMerge.sv
rtl/memMux.sv
bench/memTargetModel.sv
bench/tb_memMux.sv
